//--- hdl/buffered_serializer_pkg.sv
// shared widths, status and serial-output types for the buffered serializer
// DATA_W is limited to 2..32 because of the 5-bit bit index
// ADDR_W of at least 1, FIFO depth is 2**ADDR_W words
package buffered_serializer_pkg;

	// default word width
	localparam int DATA_W_DEFAULT = 8;

	// default FIFO address width, 8 words deep
	localparam int ADDR_W_DEFAULT = 3;

	// index of a bit within a word, counts down from DATA_W-1
	typedef logic [4:0] bit_idx_t;

	// FIFO fill status flags
	typedef struct packed {
		// 2**ADDR_W words held
		logic full;
		// nothing held
		logic empty;
		// exactly one word held
		logic last;
	} fifo_status_t;

	// serial line, one bit per ser_en tick
	typedef struct packed {
		// high on the msb of each word
		logic frame;
		// a bit is on the line
		logic valid;
		// the bit itself
		logic data;
	} ser_out_t;

	// serializer FSM
	typedef enum logic {
		SER_IDLE,
		SER_SHIFT
	} ser_state_t;

endpackage

//--- hdl/abstract_dsr.sv
// one-bit dynamic shift register with an addressed read tap
// no reset and no init value, so synthesis can map it onto one SRL16E/SRL32E
// ADDR_W must be at least 1
`timescale 1ns/1ns

module abstract_dsr #(
	parameter int ADDR_W = 4
) (
	input  logic              clk,
	input  logic              ce,
	input  logic              din,
	input  logic [ADDR_W-1:0] addr,
	output logic              dout
);

	localparam int LEN = 1 << ADDR_W;

	// newest bit sits at index 0, oldest at index LEN-1
	logic [LEN-1:0] sr;

	// shift only on enable
	always_ff @(posedge clk) begin
		if (ce) begin
			sr <= {sr[LEN-2:0], din};
		end
	end

	// read tap is purely combinational
	assign dout = sr[addr];

endmodule

//--- hdl/shortfifo.sv
// short first-word-fall-through FIFO built from per-bit shift registers
// single clock domain, depth 2**ADDR_W
// count is all ones when empty, 0 with one word, 2**ADDR_W-1 when full
// a write while full is only taken together with a read, else it is dropped
`timescale 1ns/1ns

module shortfifo import buffered_serializer_pkg::*; #(
	parameter int DATA_W = DATA_W_DEFAULT,
	parameter int ADDR_W = ADDR_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [DATA_W-1:0] din,
	input  logic              we,
	input  logic              re,
	output logic [DATA_W-1:0] dout,
	output fifo_status_t      status,
	output logic [ADDR_W:0]   count
);

	localparam int DEPTH = 1 << ADDR_W;

	// pointer value with DEPTH words held
	localparam logic [ADDR_W:0] FULL_PTR = (ADDR_W + 1)'(DEPTH - 1);

	// read pointer, one bit wider than the slice address
	// all ones means empty, wraps to zero on the first write
	logic [ADDR_W:0] raddr;

	// strobes after gating
	logic re_acc;
	logic we_acc;

	// local copies of the status flags
	logic full;
	logic empty;
	logic last;

	// one shift register per data bit, all sharing the write strobe
	// and the read address, so a whole word moves in lockstep
	genvar i;
	generate
		for (i = 0; i < DATA_W; i++) begin : bit_slice
			abstract_dsr #(
				.ADDR_W(ADDR_W)
			) srl (
				.clk (clk),
				.ce  (we_acc),
				.din (din[i]),
				.addr(raddr[ADDR_W-1:0]),
				.dout(dout[i])
			);
		end
	endgenerate

	// a pop on an empty FIFO is ignored
	assign re_acc = re && !empty;

	// while full, a write only fits if a word leaves in the same cycle
	assign we_acc = we && (!full || re_acc);

	// pointer tracks the oldest word's position in the shift chain
	// write pushes it one deeper, read pulls it one closer
	// write and read together leave it where it is
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raddr <= '1;
		end else begin
			if (we_acc && !re_acc) begin
				raddr <= raddr + 1'b1;
			end else if (re_acc && !we_acc) begin
				raddr <= raddr - 1'b1;
			end
		end
	end

	// flags decoded straight from the pointer
	assign full  = (raddr == FULL_PTR);
	assign empty = &raddr;
	assign last  = (raddr == '0);

	// pack status for the outside
	assign status.full  = full;
	assign status.empty = empty;
	assign status.last  = last;

	// fill level minus one, as a signed-looking count
	assign count = raddr;

endmodule

//--- hdl/word_serializer.sv
// pops words from a fall-through FIFO and sends them MSB first
// one bit per ser_en tick, next word follows with no gap when data waits
// ser_out is registered, re is combinational from state and FIFO status
// DATA_W from 2 to 32
`timescale 1ns/1ns

module word_serializer import buffered_serializer_pkg::*; #(
	parameter int DATA_W = DATA_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [DATA_W-1:0] word,
	input  fifo_status_t      status,
	input  logic              ser_en,
	output logic              re,
	output ser_out_t          ser_out
);

	// index of the msb, first value of the down-counter
	localparam bit_idx_t MSB_IDX = bit_idx_t'(DATA_W - 1);

	ser_state_t state;

	// word being sent, msb always holds the bit on the line
	logic [DATA_W-1:0] shreg;

	// position of the bit on the line, 0 means lsb
	bit_idx_t bit_cnt;

	// lsb on the line
	logic last_bit;

	// line moves to the next bit this cycle
	logic advance;

	assign last_bit = (bit_cnt == '0);
	assign advance  = (state == SER_SHIFT) && ser_en;

	// pop request
	// idle: take a word as soon as one is there
	// shifting: chain the next word on the tick that consumes the lsb
	// never pops when empty, so the FIFO's own read gating stays unused
	always_comb begin
		re = 1'b0;
		case (state)
			SER_IDLE: begin
				re = !status.empty;
			end
			SER_SHIFT: begin
				re = ser_en && last_bit && !status.empty;
			end
			default: begin
				re = 1'b0;
			end
		endcase
	end

	// FSM, bit counter and serial output
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SER_IDLE;
			bit_cnt <= '0;
			ser_out <= '0;
		end else begin
			if (re) begin
				// new word, msb goes out with frame
				state         <= SER_SHIFT;
				bit_cnt       <= MSB_IDX;
				ser_out.frame <= 1'b1;
				ser_out.valid <= 1'b1;
				ser_out.data  <= word[DATA_W-1];
			end else if (advance) begin
				if (last_bit) begin
					// lsb consumed and nothing waiting
					state   <= SER_IDLE;
					ser_out <= '0;
				end else begin
					bit_cnt       <= bit_cnt - 1'b1;
					ser_out.frame <= 1'b0;
					// next bit down, read before the shift below lands
					ser_out.data  <= shreg[DATA_W-2];
				end
			end
			// ser_en low holds the line steady
		end
	end

	// word payload, loaded on pop and shifted left on each tick
	always_ff @(posedge clk) begin
		if (re) begin
			shreg <= word;
		end else if (advance) begin
			shreg <= {shreg[DATA_W-2:0], 1'b0};
		end
	end

endmodule

//--- hdl/buffered_serializer.sv
// buffered serial transmitter top level
// write strobes fill a short FIFO, the serializer drains it MSB first
// single clock, no handshake, writes to a full FIFO without a pop are lost
// DATA_W 2..32, ADDR_W at least 1
`timescale 1ns/1ns

module buffered_serializer import buffered_serializer_pkg::*; #(
	parameter int DATA_W = DATA_W_DEFAULT,
	parameter int ADDR_W = ADDR_W_DEFAULT
) (
	input  logic              clk,
	input  logic              rst_n,
	// write side
	input  logic [DATA_W-1:0] in_data,
	input  logic              in_we,
	// bit-enable tick for the line
	input  logic              ser_en,
	// FIFO status
	output fifo_status_t      fifo_status,
	output logic [ADDR_W:0]   count,
	// serial line
	output ser_out_t          ser_out
);

	// oldest word, falls through combinationally
	logic [DATA_W-1:0] fifo_dout;

	// pop strobe from the serializer
	logic fifo_re;

	// word buffer
	shortfifo #(
		.DATA_W(DATA_W),
		.ADDR_W(ADDR_W)
	) u_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.din   (in_data),
		.we    (in_we),
		.re    (fifo_re),
		.dout  (fifo_dout),
		.status(fifo_status),
		.count (count)
	);

	// parallel to serial, also sees empty to decide when to pop
	word_serializer #(
		.DATA_W(DATA_W)
	) u_ser (
		.clk    (clk),
		.rst_n  (rst_n),
		.word   (fifo_dout),
		.status (fifo_status),
		.ser_en (ser_en),
		.re     (fifo_re),
		.ser_out(ser_out)
	);

endmodule

//--- test/buffered_serializer_assertions.sv
// concurrent checks for the buffered serializer, bound into the top level
// sees only the top-level ports, so the serializer's pops are inferred
// from the model's own line state and fill level
// err_count is read by the testbench when the run ends
`timescale 1ns/1ns

module buffered_serializer_assertions import buffered_serializer_pkg::*; #(
	parameter int DATA_W = DATA_W_DEFAULT,
	parameter int ADDR_W = ADDR_W_DEFAULT
) (
	input logic              clk,
	input logic              rst_n,
	input logic [DATA_W-1:0] in_data,
	input logic              in_we,
	input logic              ser_en,
	input fifo_status_t      fifo_status,
	input logic [ADDR_W:0]   count,
	input ser_out_t          ser_out
);

	localparam int DEPTH = 1 << ADDR_W;
	localparam bit_idx_t MSB_IDX = bit_idx_t'(DATA_W - 1);
	localparam logic [ADDR_W:0] FILL_FULL = (ADDR_W + 1)'(DEPTH);
	localparam logic [ADDR_W:0] FILL_ONE = (ADDR_W + 1)'(1);

	// failed checks so far
	int err_count = 0;

	// circular buffer of accepted words, oldest at head
	logic [DATA_W-1:0] mem [0:DEPTH-1];
	logic [ADDR_W-1:0] head;
	logic [ADDR_W:0]   model_fill;

	// word on the line and the index of the presented bit
	logic              line_active;
	logic [DATA_W-1:0] line_word;
	bit_idx_t          line_pos;
	logic [DATA_W-1:0] line_shifted;

	logic            pop;
	logic            push;
	logic [ADDR_W:0] exp_count;
	fifo_status_t    exp_status;
	ser_out_t        exp_out;

	// one-cycle-old port values for the hold checks
	logic [ADDR_W:0] prev_count;
	ser_out_t        prev_out;

	// a word leaves when the line is idle or its lsb is consumed
	assign pop  = (model_fill != '0) && (!line_active || (ser_en && line_pos == '0));
	// full FIFO takes a write only together with a pop
	assign push = in_we && (model_fill != FILL_FULL || pop);

	assign exp_count        = model_fill - FILL_ONE;
	assign exp_status.full  = (model_fill == FILL_FULL);
	assign exp_status.empty = (model_fill == '0);
	assign exp_status.last  = (model_fill == FILL_ONE);

	// msb first, so bit line_pos of the word is on the line
	assign line_shifted  = line_word >> line_pos;
	assign exp_out.valid = line_active;
	assign exp_out.frame = line_active && (line_pos == MSB_IDX);
	assign exp_out.data  = line_active && line_shifted[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head        <= '0;
			model_fill  <= '0;
			line_active <= 1'b0;
			line_pos    <= '0;
		end else begin
			// at full with a pop, this lands on the slot being read out
			if (push) begin
				mem[head + model_fill[ADDR_W-1:0]] <= in_data;
			end
			if (pop) begin
				head        <= head + 1'b1;
				line_word   <= mem[head];
				line_active <= 1'b1;
				line_pos    <= MSB_IDX;
			end else if (line_active && ser_en) begin
				if (line_pos == '0) begin
					line_active <= 1'b0;
				end else begin
					line_pos <= line_pos - 1'b1;
				end
			end
			model_fill <= model_fill + (ADDR_W + 1)'(push) - (ADDR_W + 1)'(pop);
		end
	end

	always_ff @(posedge clk) begin
		prev_count <= count;
		prev_out   <= ser_out;
	end

	// first edge with reset released still sees the reset values
	a_reset: assert property (@(posedge clk) $rose(rst_n) |-> (count == '1 &&
		fifo_status == 3'b010 && !ser_out.valid))
	else begin
		err_count++;
		$error("FAIL reset_state: expected count %0h status 010 valid 0, actual %0h %b %b",
			{(ADDR_W + 1){1'b1}}, $sampled(count), $sampled(fifo_status),
			$sampled(ser_out.valid));
	end

	a_count: assert property (@(posedge clk) disable iff (!rst_n) count == exp_count)
	else begin
		err_count++;
		$error("FAIL count: expected %0h, actual %0h", $sampled(exp_count), $sampled(count));
	end

	a_status: assert property (@(posedge clk) disable iff (!rst_n) fifo_status == exp_status)
	else begin
		err_count++;
		$error("FAIL status: expected %b, actual %b", $sampled(exp_status),
			$sampled(fifo_status));
	end

	a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(fifo_status.full && fifo_status.empty))
	else begin
		err_count++;
		$error("FAIL full_and_empty: expected 0, actual 1");
	end

	a_valid: assert property (@(posedge clk) disable iff (!rst_n)
		ser_out.valid == exp_out.valid)
	else begin
		err_count++;
		$error("FAIL valid: expected %b, actual %b", $sampled(exp_out.valid),
			$sampled(ser_out.valid));
	end

	a_frame: assert property (@(posedge clk) disable iff (!rst_n)
		ser_out.frame == exp_out.frame)
	else begin
		err_count++;
		$error("FAIL frame: expected %b, actual %b", $sampled(exp_out.frame),
			$sampled(ser_out.frame));
	end

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		exp_out.valid |-> ser_out.data == exp_out.data)
	else begin
		err_count++;
		$error("FAIL data: expected %b, actual %b", $sampled(exp_out.data),
			$sampled(ser_out.data));
	end

	// write at full with no pop must be lost without a trace
	a_drop: assert property (@(posedge clk) disable iff (!rst_n)
		(in_we && fifo_status.full && !pop) |=> count == prev_count)
	else begin
		err_count++;
		$error("FAIL dropped_write: expected count %0h, actual %0h", $sampled(prev_count),
			$sampled(count));
	end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ser_out.valid && !ser_en) |=> ser_out == prev_out)
	else begin
		err_count++;
		$error("FAIL hold: expected %b, actual %b", $sampled(prev_out), $sampled(ser_out));
	end

	// next msb follows the consumed lsb with no idle cycle
	a_chain: assert property (@(posedge clk) disable iff (!rst_n)
		(ser_out.valid && ser_en && line_pos == '0 && model_fill != '0) |=>
		(ser_out.valid && ser_out.frame))
	else begin
		err_count++;
		$error("FAIL back_to_back: expected valid 1 frame 1, actual %b %b",
			$sampled(ser_out.valid), $sampled(ser_out.frame));
	end

endmodule

bind buffered_serializer buffered_serializer_assertions #(
	.DATA_W(DATA_W),
	.ADDR_W(ADDR_W)
) checks (
	.clk        (clk),
	.rst_n      (rst_n),
	.in_data    (in_data),
	.in_we      (in_we),
	.ser_en     (ser_en),
	.fifo_status(fifo_status),
	.count      (count),
	.ser_out    (ser_out)
);

//--- test/buffered_serializer_tb.sv
// testbench for the buffered serializer
// all checking sits in the bound assertion module, this file drives stimulus
// phases: fill past full, free run, random traffic, drain
`timescale 1ns/1ns

module buffered_serializer_tb import buffered_serializer_pkg::*; ();

	localparam int DATA_W = DATA_W_DEFAULT;
	localparam int ADDR_W = ADDR_W_DEFAULT;
	localparam int DEPTH = 1 << ADDR_W;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam logic [31:0] SEED = 32'hb2f0_6f12;

	// phase lengths in cycles
	localparam int FILL_CYCLES = DEPTH + 6;
	localparam int FREE_CYCLES = DEPTH * DATA_W + DATA_W;
	localparam int RANDOM_CYCLES = 600;
	localparam int DRAIN_CYCLES = (DEPTH + 1) * DATA_W;
	// slack per phase
	localparam int MARGIN_CYCLES = DEPTH * DATA_W * 4;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + FILL_CYCLES + FREE_CYCLES +
		RANDOM_CYCLES + DRAIN_CYCLES + 4 * MARGIN_CYCLES;

	logic              clk = 1'b0;
	logic              rst_n;
	logic [DATA_W-1:0] in_data;
	logic              in_we;
	logic              ser_en;
	fifo_status_t      fifo_status;
	logic [ADDR_W:0]   count;
	ser_out_t          ser_out;

	buffered_serializer #(
		.DATA_W(DATA_W),
		.ADDR_W(ADDR_W)
	) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.in_we      (in_we),
		.ser_en     (ser_en),
		.fifo_status(fifo_status),
		.count      (count),
		.ser_out    (ser_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// inputs change 1 ns after the edge, well clear of sampling
	task automatic drive(input logic we, input logic [DATA_W-1:0] data, input logic en);
		@(posedge clk);
		#1;
		in_we   = we;
		in_data = data;
		ser_en  = en;
	endtask

	function automatic logic [DATA_W-1:0] random_word();
		random_word = DATA_W'($urandom());
	endfunction

	initial begin
		int i;
		int wr_thresh;
		int errors;
		void'($urandom(SEED));
		rst_n   = 1'b0;
		in_we   = 1'b0;
		in_data = '0;
		ser_en  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// fill: first word goes straight to the serializer, then DEPTH more
		// fill the FIFO, and the rest hit a full FIFO with the line stalled
		for (i = 0; i < DEPTH + 4; i++) begin
			drive(1'b1, random_word(), 1'b0);
		end
		drive(1'b0, '0, 1'b0);
		drive(1'b0, '0, 1'b0);

		// free run, writes in the first part land on full pop cycles
		for (i = 0; i < FREE_CYCLES; i++) begin
			drive(i < 2 * DATA_W, random_word(), 1'b1);
		end

		// random traffic, heavy writes first, then sparse ones
		for (i = 0; i < RANDOM_CYCLES; i++) begin
			wr_thresh = (i < RANDOM_CYCLES / 2) ? 4 : 1;
			drive(($urandom() % 16) < wr_thresh, random_word(), ($urandom() % 4) != 0);
		end

		// drain until the FIFO and the line are both idle
		drive(1'b0, '0, 1'b1);
		while (!(fifo_status.empty && !ser_out.valid)) begin
			drive(1'b0, '0, 1'b1);
		end
		repeat (4) drive(1'b0, '0, 1'b0);

		errors = UUT.checks.err_count;
		$display("assertion errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("assertion errors: %0d", UUT.checks.err_count);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- filelist.f
hdl/buffered_serializer_pkg.sv
hdl/abstract_dsr.sv
hdl/shortfifo.sv
hdl/word_serializer.sv
hdl/buffered_serializer.sv
test/buffered_serializer_assertions.sv
test/buffered_serializer_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the buffered serializer

VERILATOR  ?= verilator
TOP        := buffered_serializer_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert -Wall --top-module $(TOP)
SIM_ARGS   := +verilator+error+limit+1000
FAIL_MSG   := Simulation FAILED
PASS_MSG   := Simulation PASSED
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass report in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
